//--- build.f
id_pkg.sv
id_fetch_latch.sv
id_decoder.sv
id_operand_sel.sv
id_branch_unit.sv
id_ex_reg.sv
id_stage.sv
tb_id_stage.sv

//--- id_branch_unit.sv
`timescale 1ns/1ns

module id_branch_unit (
	input  logic [id_pkg::aluop_w-1:0] aluop_i,
	input  logic [id_pkg::word_w-1:0]  pc_i,
	input  id_pkg::instr_u             inst_i,
	input  logic [id_pkg::word_w-1:0]  op1_i,
	input  logic [id_pkg::word_w-1:0]  op2_i,
	output logic                       branch_flag_o,
	output logic [id_pkg::word_w-1:0]  branch_target_o,
	output logic [id_pkg::word_w-1:0]  link_addr_o,
	output logic                       next_in_delayslot_o
);

	logic [id_pkg::word_w-1:0] pc_plus_4;
	logic [id_pkg::word_w-1:0] pc_plus_8;	// skips the delay slot
	logic [id_pkg::word_w-1:0] b_target;
	logic [id_pkg::word_w-1:0] j_target;
	logic [id_pkg::word_w-1:0] target;
	logic                      taken;

	assign pc_plus_4 = pc_i + 32'd4;
	assign pc_plus_8 = pc_i + 32'd8;
	assign b_target  = pc_plus_4 + {{14{inst_i.i.imm16[15]}}, inst_i.i.imm16, 2'b00};
	assign j_target  = {pc_plus_4[31:28], inst_i.j.target26, 2'b00};	// same 256 MB region

	always_comb begin
		taken       = 1'b1;
		target      = b_target;
		link_addr_o = '0;
		case (aluop_i)
			id_pkg::aluop_beq:  taken = (op1_i == op2_i);
			id_pkg::aluop_bne:  taken = (op1_i != op2_i);
			id_pkg::aluop_bgtz: taken = !op1_i[31] && (op1_i != '0);
			id_pkg::aluop_blez: taken = op1_i[31] || (op1_i == '0);
			id_pkg::aluop_bgez: taken = !op1_i[31];
			id_pkg::aluop_bltz: taken = op1_i[31];
			id_pkg::aluop_j:    target = j_target;
			id_pkg::aluop_jal: begin
				target      = j_target;
				link_addr_o = pc_plus_8;
			end
			id_pkg::aluop_jr:   target = op1_i;
			id_pkg::aluop_jalr: begin
				target      = op1_i;
				link_addr_o = pc_plus_8;
			end
			default:            taken = 1'b0;
		endcase
	end

	assign branch_flag_o       = taken;
	assign next_in_delayslot_o = taken;	// next fetched word sits in the slot
	assign branch_target_o     = taken ? target : '0;

endmodule

//--- id_decoder.sv
`timescale 1ns/1ns

module id_decoder (
	input  id_pkg::instr_u                  inst_i,
	output logic [id_pkg::aluop_w-1:0]      aluop_o,
	output logic [id_pkg::alusel_w-1:0]     alusel_o,
	output logic [id_pkg::reg_addr_w-1:0]   wd_o,
	output logic                            wreg_o,
	output logic                            reg1_read_o,
	output logic                            reg2_read_o,
	output logic [id_pkg::reg_addr_w-1:0]   reg1_addr_o,
	output logic [id_pkg::reg_addr_w-1:0]   reg2_addr_o,
	output logic [id_pkg::word_w-1:0]       imm_o,
	output logic                            inst_valid_o
);

	logic [id_pkg::aluop_w-1:0]  code;
	logic [id_pkg::alusel_w-1:0] sel;	// sel_nop here means not decodable
	logic                        shamt_form;	// sll/srl/sra
	logic [id_pkg::word_w-1:0]   imm_sext;
	logic [id_pkg::word_w-1:0]   imm_alu;

	assign shamt_form = (inst_i.r.funct == id_pkg::fn_sll) ||
	                    (inst_i.r.funct == id_pkg::fn_srl) ||
	                    (inst_i.r.funct == id_pkg::fn_sra);
	assign imm_sext = {{16{inst_i.i.imm16[15]}}, inst_i.i.imm16};
	assign imm_alu  = (inst_i.i.op == id_pkg::op_lui) ? {inst_i.i.imm16, 16'h0000} :
	                  (sel == id_pkg::sel_logic)      ? {16'h0000, inst_i.i.imm16} : imm_sext;

	//////////////////////////////////////////////////
	// opcode table
	always_comb begin
		{code, sel} = {id_pkg::aluop_nop, id_pkg::sel_nop};
		case (inst_i.i.op)
			id_pkg::op_special: begin
				// shift-immediate forms need rs clear, the rest need sa clear
				if (shamt_form ? (inst_i.r.rs == '0) : (inst_i.r.sa == '0)) begin
					case (inst_i.r.funct)
						id_pkg::fn_or:   {code, sel} = {id_pkg::aluop_or, id_pkg::sel_logic};
						id_pkg::fn_and:  {code, sel} = {id_pkg::aluop_and, id_pkg::sel_logic};
						id_pkg::fn_xor:  {code, sel} = {id_pkg::aluop_xor, id_pkg::sel_logic};
						id_pkg::fn_nor:  {code, sel} = {id_pkg::aluop_nor, id_pkg::sel_logic};
						id_pkg::fn_sll:  {code, sel} = {id_pkg::aluop_sll, id_pkg::sel_shift};
						id_pkg::fn_srl:  {code, sel} = {id_pkg::aluop_srl, id_pkg::sel_shift};
						id_pkg::fn_sra:  {code, sel} = {id_pkg::aluop_sra, id_pkg::sel_shift};
						id_pkg::fn_sllv: {code, sel} = {id_pkg::aluop_sll, id_pkg::sel_shift};
						id_pkg::fn_srlv: {code, sel} = {id_pkg::aluop_srl, id_pkg::sel_shift};
						id_pkg::fn_srav: {code, sel} = {id_pkg::aluop_sra, id_pkg::sel_shift};
						id_pkg::fn_add:  {code, sel} = {id_pkg::aluop_add, id_pkg::sel_arith};
						id_pkg::fn_addu: {code, sel} = {id_pkg::aluop_addu, id_pkg::sel_arith};
						id_pkg::fn_sub:  {code, sel} = {id_pkg::aluop_sub, id_pkg::sel_arith};
						id_pkg::fn_subu: {code, sel} = {id_pkg::aluop_subu, id_pkg::sel_arith};
						id_pkg::fn_slt:  {code, sel} = {id_pkg::aluop_slt, id_pkg::sel_arith};
						id_pkg::fn_sltu: {code, sel} = {id_pkg::aluop_sltu, id_pkg::sel_arith};
						id_pkg::fn_jr:   {code, sel} = {id_pkg::aluop_jr, id_pkg::sel_jump};
						id_pkg::fn_jalr: {code, sel} = {id_pkg::aluop_jalr, id_pkg::sel_jump};
						default:         {code, sel} = {id_pkg::aluop_nop, id_pkg::sel_nop};
					endcase
				end
			end
			id_pkg::op_regimm: begin
				if (inst_i.i.rt == id_pkg::rt_bltz)
					{code, sel} = {id_pkg::aluop_bltz, id_pkg::sel_jump};
				else if (inst_i.i.rt == id_pkg::rt_bgez)
					{code, sel} = {id_pkg::aluop_bgez, id_pkg::sel_jump};
			end
			id_pkg::op_ori:   {code, sel} = {id_pkg::aluop_or, id_pkg::sel_logic};
			id_pkg::op_andi:  {code, sel} = {id_pkg::aluop_and, id_pkg::sel_logic};
			id_pkg::op_xori:  {code, sel} = {id_pkg::aluop_xor, id_pkg::sel_logic};
			id_pkg::op_lui:   {code, sel} = {id_pkg::aluop_or, id_pkg::sel_logic};	// rs | imm<<16
			id_pkg::op_addi:  {code, sel} = {id_pkg::aluop_addi, id_pkg::sel_arith};
			id_pkg::op_addiu: {code, sel} = {id_pkg::aluop_addiu, id_pkg::sel_arith};
			id_pkg::op_slti:  {code, sel} = {id_pkg::aluop_slt, id_pkg::sel_arith};
			id_pkg::op_sltiu: {code, sel} = {id_pkg::aluop_sltu, id_pkg::sel_arith};
			id_pkg::op_lw:    {code, sel} = {id_pkg::aluop_lw, id_pkg::sel_mem};
			id_pkg::op_sw:    {code, sel} = {id_pkg::aluop_sw, id_pkg::sel_mem};
			id_pkg::op_beq:   {code, sel} = {id_pkg::aluop_beq, id_pkg::sel_jump};
			id_pkg::op_bne:   {code, sel} = {id_pkg::aluop_bne, id_pkg::sel_jump};
			id_pkg::op_bgtz:  {code, sel} = {id_pkg::aluop_bgtz, id_pkg::sel_jump};
			id_pkg::op_blez:  {code, sel} = {id_pkg::aluop_blez, id_pkg::sel_jump};
			id_pkg::op_j:     {code, sel} = {id_pkg::aluop_j, id_pkg::sel_jump};
			id_pkg::op_jal:   {code, sel} = {id_pkg::aluop_jal, id_pkg::sel_jump};
			default:          {code, sel} = {id_pkg::aluop_nop, id_pkg::sel_nop};
		endcase
	end

	assign aluop_o      = code;
	assign alusel_o     = sel;
	assign inst_valid_o = (sel != id_pkg::sel_nop);
	assign reg1_addr_o  = inst_i.r.rs;
	assign reg2_addr_o  = inst_i.r.rt;

	//////////////////////////////////////////////////
	// register usage and immediate
	always_comb begin
		wd_o        = inst_i.r.rd;
		wreg_o      = 1'b0;
		reg1_read_o = 1'b0;
		reg2_read_o = 1'b0;
		imm_o       = '0;
		if (inst_valid_o) begin
			case (inst_i.i.op)
				id_pkg::op_special: begin
					wreg_o      = (inst_i.r.funct != id_pkg::fn_jr);
					reg1_read_o = !shamt_form;
					reg2_read_o = (sel != id_pkg::sel_jump);
					imm_o       = shamt_form ? {27'b0, inst_i.r.sa} : '0;
				end
				id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui,
				id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu,
				id_pkg::op_lw: begin
					wd_o        = inst_i.i.rt;
					wreg_o      = 1'b1;
					reg1_read_o = 1'b1;
					imm_o       = imm_alu;
				end
				id_pkg::op_sw: begin
					reg1_read_o = 1'b1;	// base
					reg2_read_o = 1'b1;	// store data
					imm_o       = imm_sext;
				end
				id_pkg::op_beq, id_pkg::op_bne: begin
					reg1_read_o = 1'b1;
					reg2_read_o = 1'b1;
				end
				id_pkg::op_regimm, id_pkg::op_bgtz, id_pkg::op_blez: reg1_read_o = 1'b1;
				id_pkg::op_jal: begin
					wd_o   = id_pkg::link_reg;
					wreg_o = 1'b1;
				end
				default: wreg_o = 1'b0;	// j uses no registers
			endcase
		end
	end

endmodule

//--- id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic                          stall_i,
	input  logic [id_pkg::aluop_w-1:0]    aluop_i,
	input  logic [id_pkg::alusel_w-1:0]   alusel_i,
	input  logic [id_pkg::reg_addr_w-1:0] wd_i,
	input  logic                          wreg_i,
	input  logic [id_pkg::word_w-1:0]     op1_i,
	input  logic [id_pkg::word_w-1:0]     op2_i,
	input  logic [id_pkg::word_w-1:0]     link_addr_i,
	input  logic                          in_delayslot_i,
	input  logic                          inst_valid_i,
	output logic [id_pkg::aluop_w-1:0]    ex_aluop_o,
	output logic [id_pkg::alusel_w-1:0]   ex_alusel_o,
	output logic [id_pkg::reg_addr_w-1:0] ex_wd_o,
	output logic                          ex_wreg_o,
	output logic [id_pkg::word_w-1:0]     ex_reg1_o,
	output logic [id_pkg::word_w-1:0]     ex_reg2_o,
	output logic [id_pkg::word_w-1:0]     ex_link_addr_o,
	output logic                          ex_in_delayslot_o,
	output logic                          inst_invalid_o
);

	always_ff @(posedge clk) begin
		if (reset_i || stall_i) begin	// bubble: execute sees a nop
			ex_aluop_o        <= id_pkg::aluop_nop;
			ex_alusel_o       <= id_pkg::sel_nop;
			ex_wd_o           <= id_pkg::nop_reg;
			ex_wreg_o         <= 1'b0;
			ex_reg1_o         <= '0;
			ex_reg2_o         <= '0;
			ex_link_addr_o    <= '0;
			ex_in_delayslot_o <= 1'b0;
			inst_invalid_o    <= 1'b0;
		end else begin
			ex_aluop_o        <= aluop_i;
			ex_alusel_o       <= alusel_i;
			ex_wd_o           <= wd_i;
			ex_wreg_o         <= wreg_i;
			ex_reg1_o         <= op1_i;
			ex_reg2_o         <= op2_i;
			ex_link_addr_o    <= link_addr_i;
			ex_in_delayslot_o <= in_delayslot_i;
			inst_invalid_o    <= !inst_valid_i;	// feeds the reserved-instruction trap
		end
	end

endmodule

//--- id_fetch_latch.sv
`timescale 1ns/1ns

module id_fetch_latch (
	input  logic                      clk,
	input  logic                      reset_i,
	input  logic                      if_valid_i,
	input  logic                      stall_i,
	input  logic [id_pkg::word_w-1:0] pc_i,
	input  logic [id_pkg::word_w-1:0] inst_i,
	input  logic                      in_delayslot_i,
	output logic [id_pkg::word_w-1:0] pc_o,
	output id_pkg::instr_u            inst_o,
	output logic                      in_delayslot_o
);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_o           <= '0;
			inst_o         <= '0;
			in_delayslot_o <= 1'b0;
		end else if (!stall_i) begin	// hold while decode waits on a load
			if (if_valid_i) begin
				pc_o           <= pc_i;
				inst_o         <= inst_i;
				in_delayslot_o <= in_delayslot_i;
			end else begin
				// empty fetch slot becomes sll r0,r0,0
				pc_o           <= '0;
				inst_o         <= '0;
				in_delayslot_o <= 1'b0;
			end
		end
	end

endmodule

//--- id_operand_sel.sv
`timescale 1ns/1ns

module id_operand_sel (
	input  logic                          reg1_read_i,
	input  logic                          reg2_read_i,
	input  logic [id_pkg::reg_addr_w-1:0] reg1_addr_i,
	input  logic [id_pkg::reg_addr_w-1:0] reg2_addr_i,
	input  logic [id_pkg::word_w-1:0]     imm_i,
	input  logic [id_pkg::word_w-1:0]     reg1_data_i,
	input  logic [id_pkg::word_w-1:0]     reg2_data_i,
	input  logic                          ex_wreg_i,
	input  logic                          ex_load_i,
	input  logic [id_pkg::reg_addr_w-1:0] ex_wd_i,
	input  logic [id_pkg::word_w-1:0]     ex_wdata_i,
	input  logic                          mem_wreg_i,
	input  logic [id_pkg::reg_addr_w-1:0] mem_wd_i,
	input  logic [id_pkg::word_w-1:0]     mem_wdata_i,
	output logic [id_pkg::word_w-1:0]     op1_o,
	output logic [id_pkg::word_w-1:0]     op2_o,
	output logic                          stall_o
);

	logic stall1;
	logic stall2;

	// returns {load-use hit, operand}, nearest producer first
	function automatic logic [id_pkg::word_w:0] pick(
		input logic                          rd_en,
		input logic [id_pkg::reg_addr_w-1:0] addr,
		input logic [id_pkg::word_w-1:0]     rf_data
	);
		if (rd_en && ex_load_i && (ex_wd_i == addr))
			return {1'b1, {id_pkg::word_w{1'b0}}};	// lw result not ready yet
		else if (rd_en && ex_wreg_i && (ex_wd_i == addr))
			return {1'b0, ex_wdata_i};
		else if (rd_en && mem_wreg_i && (mem_wd_i == addr))
			return {1'b0, mem_wdata_i};
		else if (rd_en)
			return {1'b0, rf_data};
		else
			return {1'b0, imm_i};
	endfunction

	always_comb begin
		{stall1, op1_o} = pick(reg1_read_i, reg1_addr_i, reg1_data_i);
		{stall2, op2_o} = pick(reg2_read_i, reg2_addr_i, reg2_data_i);
	end

	assign stall_o = stall1 | stall2;

endmodule

//--- id_pkg.sv
package id_pkg;

	//////////////////////////////////////////////////
	// widths and fixed registers
	localparam int word_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int aluop_w    = 8;
	localparam int alusel_w   = 3;

	localparam logic [reg_addr_w-1:0] link_reg = 5'd31;	// jal destination
	localparam logic [reg_addr_w-1:0] nop_reg  = 5'd0;

	//////////////////////////////////////////////////
	// primary opcodes
	localparam logic [5:0] op_special = 6'b000000;
	localparam logic [5:0] op_regimm  = 6'b000001;
	localparam logic [5:0] op_j       = 6'b000010;
	localparam logic [5:0] op_jal     = 6'b000011;
	localparam logic [5:0] op_beq     = 6'b000100;
	localparam logic [5:0] op_bne     = 6'b000101;
	localparam logic [5:0] op_blez    = 6'b000110;
	localparam logic [5:0] op_bgtz    = 6'b000111;
	localparam logic [5:0] op_addi    = 6'b001000;
	localparam logic [5:0] op_addiu   = 6'b001001;
	localparam logic [5:0] op_slti    = 6'b001010;
	localparam logic [5:0] op_sltiu   = 6'b001011;
	localparam logic [5:0] op_andi    = 6'b001100;
	localparam logic [5:0] op_ori     = 6'b001101;
	localparam logic [5:0] op_xori    = 6'b001110;
	localparam logic [5:0] op_lui     = 6'b001111;
	localparam logic [5:0] op_lw      = 6'b100011;
	localparam logic [5:0] op_sw      = 6'b101011;

	// special funct field
	localparam logic [5:0] fn_sll  = 6'b000000;
	localparam logic [5:0] fn_srl  = 6'b000010;
	localparam logic [5:0] fn_sra  = 6'b000011;
	localparam logic [5:0] fn_sllv = 6'b000100;
	localparam logic [5:0] fn_srlv = 6'b000110;
	localparam logic [5:0] fn_srav = 6'b000111;
	localparam logic [5:0] fn_jr   = 6'b001000;
	localparam logic [5:0] fn_jalr = 6'b001001;
	localparam logic [5:0] fn_add  = 6'b100000;
	localparam logic [5:0] fn_addu = 6'b100001;
	localparam logic [5:0] fn_sub  = 6'b100010;
	localparam logic [5:0] fn_subu = 6'b100011;
	localparam logic [5:0] fn_and  = 6'b100100;
	localparam logic [5:0] fn_or   = 6'b100101;
	localparam logic [5:0] fn_xor  = 6'b100110;
	localparam logic [5:0] fn_nor  = 6'b100111;
	localparam logic [5:0] fn_slt  = 6'b101010;
	localparam logic [5:0] fn_sltu = 6'b101011;

	localparam logic [4:0] rt_bltz = 5'b00000;	// regimm selectors
	localparam logic [4:0] rt_bgez = 5'b00001;

	//////////////////////////////////////////////////
	// execute-stage operation codes
	localparam logic [aluop_w-1:0] aluop_nop   = 8'b00000000;
	localparam logic [aluop_w-1:0] aluop_and   = 8'b00100100;
	localparam logic [aluop_w-1:0] aluop_or    = 8'b00100101;
	localparam logic [aluop_w-1:0] aluop_xor   = 8'b00100110;
	localparam logic [aluop_w-1:0] aluop_nor   = 8'b00100111;
	localparam logic [aluop_w-1:0] aluop_sll   = 8'b01111100;
	localparam logic [aluop_w-1:0] aluop_srl   = 8'b00000010;
	localparam logic [aluop_w-1:0] aluop_sra   = 8'b00000011;
	localparam logic [aluop_w-1:0] aluop_slt   = 8'b00101010;
	localparam logic [aluop_w-1:0] aluop_sltu  = 8'b00101011;
	localparam logic [aluop_w-1:0] aluop_add   = 8'b00100000;
	localparam logic [aluop_w-1:0] aluop_addu  = 8'b00100001;
	localparam logic [aluop_w-1:0] aluop_sub   = 8'b00100010;
	localparam logic [aluop_w-1:0] aluop_subu  = 8'b00100011;
	localparam logic [aluop_w-1:0] aluop_addi  = 8'b01010101;
	localparam logic [aluop_w-1:0] aluop_addiu = 8'b01010110;
	localparam logic [aluop_w-1:0] aluop_lw    = 8'b11100011;
	localparam logic [aluop_w-1:0] aluop_sw    = 8'b11101011;
	localparam logic [aluop_w-1:0] aluop_j     = 8'b01001111;
	localparam logic [aluop_w-1:0] aluop_jal   = 8'b01010000;
	localparam logic [aluop_w-1:0] aluop_jr    = 8'b00001000;
	localparam logic [aluop_w-1:0] aluop_jalr  = 8'b00001001;
	localparam logic [aluop_w-1:0] aluop_beq   = 8'b01010001;
	localparam logic [aluop_w-1:0] aluop_bne   = 8'b01010010;
	localparam logic [aluop_w-1:0] aluop_blez  = 8'b01010011;
	localparam logic [aluop_w-1:0] aluop_bgtz  = 8'b01010100;
	localparam logic [aluop_w-1:0] aluop_bltz  = 8'b01000000;
	localparam logic [aluop_w-1:0] aluop_bgez  = 8'b01000001;

	// result class, picks the execute-stage result mux
	localparam logic [alusel_w-1:0] sel_nop   = 3'b000;
	localparam logic [alusel_w-1:0] sel_logic = 3'b001;
	localparam logic [alusel_w-1:0] sel_shift = 3'b010;
	localparam logic [alusel_w-1:0] sel_arith = 3'b100;
	localparam logic [alusel_w-1:0] sel_jump  = 3'b110;
	localparam logic [alusel_w-1:0] sel_mem   = 3'b111;

	//////////////////////////////////////////////////
	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0]            op;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;
			logic [reg_addr_w-1:0] rd;
			logic [4:0]            sa;
			logic [5:0]            funct;
		} r;
		struct packed {
			logic [5:0]            op;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;
			logic [15:0]           imm16;
		} i;
		struct packed {
			logic [5:0]  op;
			logic [25:0] target26;
		} j;
	} instr_u;

endpackage

//--- id_stage.sv
`timescale 1ns/1ns

module id_stage (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic                          if_valid_i,
	input  logic [id_pkg::word_w-1:0]     pc_i,
	input  logic [id_pkg::word_w-1:0]     inst_i,
	input  logic                          in_delayslot_i,
	input  logic [id_pkg::word_w-1:0]     reg1_data_i,
	input  logic [id_pkg::word_w-1:0]     reg2_data_i,
	input  logic                          ex_wreg_i,
	input  logic                          ex_load_i,
	input  logic [id_pkg::reg_addr_w-1:0] ex_wd_i,
	input  logic [id_pkg::word_w-1:0]     ex_wdata_i,
	input  logic                          mem_wreg_i,
	input  logic [id_pkg::reg_addr_w-1:0] mem_wd_i,
	input  logic [id_pkg::word_w-1:0]     mem_wdata_i,
	output logic                          reg1_read_o,
	output logic                          reg2_read_o,
	output logic [id_pkg::reg_addr_w-1:0] reg1_addr_o,
	output logic [id_pkg::reg_addr_w-1:0] reg2_addr_o,
	output logic                          stall_o,
	output logic                          branch_flag_o,
	output logic [id_pkg::word_w-1:0]     branch_target_o,
	output logic                          next_in_delayslot_o,
	output logic [id_pkg::aluop_w-1:0]    ex_aluop_o,
	output logic [id_pkg::alusel_w-1:0]   ex_alusel_o,
	output logic [id_pkg::reg_addr_w-1:0] ex_wd_o,
	output logic                          ex_wreg_o,
	output logic [id_pkg::word_w-1:0]     ex_reg1_o,
	output logic [id_pkg::word_w-1:0]     ex_reg2_o,
	output logic [id_pkg::word_w-1:0]     ex_link_addr_o,
	output logic                          ex_in_delayslot_o,
	output logic                          inst_invalid_o
);

	logic [id_pkg::word_w-1:0]     cur_pc;
	id_pkg::instr_u                cur_inst;
	logic                          cur_delayslot;
	logic [id_pkg::aluop_w-1:0]    aluop;
	logic [id_pkg::alusel_w-1:0]   alusel;
	logic [id_pkg::reg_addr_w-1:0] wd;
	logic                          wreg;
	logic [id_pkg::word_w-1:0]     imm;
	logic                          inst_valid;
	logic [id_pkg::word_w-1:0]     op1;
	logic [id_pkg::word_w-1:0]     op2;
	logic [id_pkg::word_w-1:0]     link_addr;

	id_fetch_latch u_latch (
		.clk(clk), .reset_i(reset_i), .if_valid_i(if_valid_i), .stall_i(stall_o),
		.pc_i(pc_i), .inst_i(inst_i), .in_delayslot_i(in_delayslot_i),
		.pc_o(cur_pc), .inst_o(cur_inst), .in_delayslot_o(cur_delayslot)
	);

	id_decoder u_dec (
		.inst_i(cur_inst), .aluop_o(aluop), .alusel_o(alusel), .wd_o(wd), .wreg_o(wreg),
		.reg1_read_o(reg1_read_o), .reg2_read_o(reg2_read_o),
		.reg1_addr_o(reg1_addr_o), .reg2_addr_o(reg2_addr_o),
		.imm_o(imm), .inst_valid_o(inst_valid)
	);

	id_operand_sel u_opsel (
		.reg1_read_i(reg1_read_o), .reg2_read_i(reg2_read_o),
		.reg1_addr_i(reg1_addr_o), .reg2_addr_i(reg2_addr_o), .imm_i(imm),
		.reg1_data_i(reg1_data_i), .reg2_data_i(reg2_data_i),
		.ex_wreg_i(ex_wreg_i), .ex_load_i(ex_load_i), .ex_wd_i(ex_wd_i),
		.ex_wdata_i(ex_wdata_i), .mem_wreg_i(mem_wreg_i), .mem_wd_i(mem_wd_i),
		.mem_wdata_i(mem_wdata_i), .op1_o(op1), .op2_o(op2), .stall_o(stall_o)
	);

	id_branch_unit u_br (
		.aluop_i(aluop), .pc_i(cur_pc), .inst_i(cur_inst), .op1_i(op1), .op2_i(op2),
		.branch_flag_o(branch_flag_o), .branch_target_o(branch_target_o),
		.link_addr_o(link_addr), .next_in_delayslot_o(next_in_delayslot_o)
	);

	id_ex_reg u_idex (
		.clk(clk), .reset_i(reset_i), .stall_i(stall_o),
		.aluop_i(aluop), .alusel_i(alusel), .wd_i(wd), .wreg_i(wreg),
		.op1_i(op1), .op2_i(op2), .link_addr_i(link_addr),
		.in_delayslot_i(cur_delayslot), .inst_valid_i(inst_valid),
		.ex_aluop_o(ex_aluop_o), .ex_alusel_o(ex_alusel_o), .ex_wd_o(ex_wd_o),
		.ex_wreg_o(ex_wreg_o), .ex_reg1_o(ex_reg1_o), .ex_reg2_o(ex_reg2_o),
		.ex_link_addr_o(ex_link_addr_o), .ex_in_delayslot_o(ex_in_delayslot_o),
		.inst_invalid_o(inst_invalid_o)
	);

endmodule

//--- run.sh
#!/bin/sh
verilator --binary --timing -f build.f --top-module tb_id_stage -o sim_id_stage > build.log 2>&1 && ./obj_dir/sim_id_stage > sim.log 2>&1 || echo "build or simulation error"
grep -q "^TEST PASSED$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;

	localparam int num_instr = 2000;
	localparam int cycle_limit = 8 + 4 * num_instr;	// reset plus worst-case stalls

	localparam logic [5:0] fn_tab [18] = '{
		id_pkg::fn_or, id_pkg::fn_and, id_pkg::fn_xor, id_pkg::fn_nor, id_pkg::fn_sll,
		id_pkg::fn_srl, id_pkg::fn_sra, id_pkg::fn_sllv, id_pkg::fn_srlv, id_pkg::fn_srav,
		id_pkg::fn_add, id_pkg::fn_addu, id_pkg::fn_sub, id_pkg::fn_subu, id_pkg::fn_slt,
		id_pkg::fn_sltu, id_pkg::fn_jr, id_pkg::fn_jalr};
	localparam logic [5:0] op_tab [17] = '{
		id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori, id_pkg::op_lui, id_pkg::op_addi,
		id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu, id_pkg::op_lw, id_pkg::op_sw,
		id_pkg::op_beq, id_pkg::op_bne, id_pkg::op_bgtz, id_pkg::op_blez, id_pkg::op_j,
		id_pkg::op_jal, id_pkg::op_regimm};

	logic clk = 1'b0;
	logic reset_i, if_valid_i, in_delayslot_i;
	logic [31:0] pc_i, inst_i, reg1_data_i, reg2_data_i;
	logic ex_wreg_i, ex_load_i, mem_wreg_i;
	logic [4:0] ex_wd_i, mem_wd_i;
	logic [31:0] ex_wdata_i, mem_wdata_i;
	logic reg1_read_o, reg2_read_o, stall_o, branch_flag_o, next_in_delayslot_o;
	logic [4:0] reg1_addr_o, reg2_addr_o, ex_wd_o;
	logic [31:0] branch_target_o, ex_reg1_o, ex_reg2_o, ex_link_addr_o;
	logic [7:0] ex_aluop_o;
	logic [2:0] ex_alusel_o;
	logic ex_wreg_o, ex_in_delayslot_o, inst_invalid_o;

	logic [31:0] seed = 32'h89f7;
	logic [31:0] rf [32];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	logic started = 1'b0;

	// model of the fetch latch with the current and next ID/EX contents
	logic [31:0] m_pc = '0, m_inst = '0;
	logic m_ds = 1'b0, m_stall = 1'b0;
	logic [7:0] e_op, n_op;
	logic [2:0] e_sel, n_sel;
	logic [4:0] e_wd, n_wd;
	logic e_wr, n_wr, e_ds, n_ds, e_inv, n_inv;
	logic [31:0] e_r1, n_r1, e_r2, n_r2, e_link, n_link;

	always #20 clk = ~clk;

	assign reg1_data_i = rf[reg1_addr_o];	// async regfile read
	assign reg2_data_i = rf[reg2_addr_o];

	id_stage uut (.*);

	function automatic logic [31:0] next_rand();
		seed ^= seed << 13;
		seed ^= seed >> 17;
		seed ^= seed << 5;
		return seed;
	endfunction

	function automatic logic [31:0] gen_inst();
		logic [31:0] r;
		logic [31:0] w;
		logic [5:0] f;
		int idx;
		r = next_rand();
		w = next_rand();
		if (r[2:0] == 3'd0)
			return w;	// mostly undecodable
		if (r[3]) begin
			idx = int'(r[15:8] % 8'd18);
			f = fn_tab[idx];
			if (f == id_pkg::fn_sll || f == id_pkg::fn_srl || f == id_pkg::fn_sra)
				return {6'b0, 5'b0, 2'b0, w[18:16], 2'b0, w[13:11], w[10:6], f};
			return {6'b0, 2'b0, w[23:21], 2'b0, w[18:16], 2'b0, w[13:11], 5'b0, f};
		end
		idx = int'(r[15:8] % 8'd17);
		if (op_tab[idx] == id_pkg::op_regimm)
			return {op_tab[idx], 2'b0, w[23:21], 4'b0, r[9], w[15:0]};
		return {op_tab[idx], 2'b0, w[23:21], 2'b0, w[18:16], w[15:0]};
	endfunction

	// decode table straight from the instruction set
	task automatic decode_word(input logic [31:0] w, output logic [7:0] op,
			output logic [2:0] sel, output logic [4:0] wd, output logic wr,
			output logic r1, output logic r2, output logic [31:0] imm);
		logic [5:0] fn;
		logic shamt;
		fn = w[5:0];
		shamt = (fn == id_pkg::fn_sll) || (fn == id_pkg::fn_srl) || (fn == id_pkg::fn_sra);
		{op, sel} = {id_pkg::aluop_nop, id_pkg::sel_nop};
		{wd, wr, r1, r2, imm} = {w[15:11], 3'b000, 32'h0};
		case (w[31:26])
			id_pkg::op_special: begin
				if (shamt ? (w[25:21] == 5'd0) : (w[10:6] == 5'd0)) begin
					case (fn)
						id_pkg::fn_or:   {op, sel} = {id_pkg::aluop_or, id_pkg::sel_logic};
						id_pkg::fn_and:  {op, sel} = {id_pkg::aluop_and, id_pkg::sel_logic};
						id_pkg::fn_xor:  {op, sel} = {id_pkg::aluop_xor, id_pkg::sel_logic};
						id_pkg::fn_nor:  {op, sel} = {id_pkg::aluop_nor, id_pkg::sel_logic};
						id_pkg::fn_sll, id_pkg::fn_sllv:
							{op, sel} = {id_pkg::aluop_sll, id_pkg::sel_shift};
						id_pkg::fn_srl, id_pkg::fn_srlv:
							{op, sel} = {id_pkg::aluop_srl, id_pkg::sel_shift};
						id_pkg::fn_sra, id_pkg::fn_srav:
							{op, sel} = {id_pkg::aluop_sra, id_pkg::sel_shift};
						id_pkg::fn_add:  {op, sel} = {id_pkg::aluop_add, id_pkg::sel_arith};
						id_pkg::fn_addu: {op, sel} = {id_pkg::aluop_addu, id_pkg::sel_arith};
						id_pkg::fn_sub:  {op, sel} = {id_pkg::aluop_sub, id_pkg::sel_arith};
						id_pkg::fn_subu: {op, sel} = {id_pkg::aluop_subu, id_pkg::sel_arith};
						id_pkg::fn_slt:  {op, sel} = {id_pkg::aluop_slt, id_pkg::sel_arith};
						id_pkg::fn_sltu: {op, sel} = {id_pkg::aluop_sltu, id_pkg::sel_arith};
						id_pkg::fn_jr:   {op, sel} = {id_pkg::aluop_jr, id_pkg::sel_jump};
						id_pkg::fn_jalr: {op, sel} = {id_pkg::aluop_jalr, id_pkg::sel_jump};
						default: ;
					endcase
					if (sel != id_pkg::sel_nop)
						{wr, r1, r2} = 3'b111;
					if (shamt) begin
						r1 = 1'b0;
						imm = {27'b0, w[10:6]};
					end
					if (sel == id_pkg::sel_jump)
						{wr, r2} = {fn == id_pkg::fn_jalr, 1'b0};	// jr links nothing
				end
			end
			id_pkg::op_regimm: begin
				if (w[20:16] == id_pkg::rt_bltz)
					{op, sel, r1} = {id_pkg::aluop_bltz, id_pkg::sel_jump, 1'b1};
				else if (w[20:16] == id_pkg::rt_bgez)
					{op, sel, r1} = {id_pkg::aluop_bgez, id_pkg::sel_jump, 1'b1};
			end
			id_pkg::op_ori, id_pkg::op_andi, id_pkg::op_xori: begin
				op = (w[31:26] == id_pkg::op_ori) ? id_pkg::aluop_or :
				     (w[31:26] == id_pkg::op_andi) ? id_pkg::aluop_and : id_pkg::aluop_xor;
				{sel, wd, wr, r1, imm} = {id_pkg::sel_logic, w[20:16], 2'b11, 16'h0, w[15:0]};
			end
			id_pkg::op_lui:
				{op, sel, wd, wr, r1, imm} = {id_pkg::aluop_or, id_pkg::sel_logic, w[20:16],
					2'b11, w[15:0], 16'h0};
			id_pkg::op_addi, id_pkg::op_addiu, id_pkg::op_slti, id_pkg::op_sltiu,
			id_pkg::op_lw: begin
				case (w[31:26])
					id_pkg::op_addi:  {op, sel} = {id_pkg::aluop_addi, id_pkg::sel_arith};
					id_pkg::op_addiu: {op, sel} = {id_pkg::aluop_addiu, id_pkg::sel_arith};
					id_pkg::op_slti:  {op, sel} = {id_pkg::aluop_slt, id_pkg::sel_arith};
					id_pkg::op_sltiu: {op, sel} = {id_pkg::aluop_sltu, id_pkg::sel_arith};
					default:          {op, sel} = {id_pkg::aluop_lw, id_pkg::sel_mem};
				endcase
				{wd, wr, r1, imm} = {w[20:16], 2'b11, {16{w[15]}}, w[15:0]};
			end
			id_pkg::op_sw:
				{op, sel, r1, r2, imm} = {id_pkg::aluop_sw, id_pkg::sel_mem, 2'b11,
					{16{w[15]}}, w[15:0]};
			id_pkg::op_beq: {op, sel, r1, r2} = {id_pkg::aluop_beq, id_pkg::sel_jump, 2'b11};
			id_pkg::op_bne: {op, sel, r1, r2} = {id_pkg::aluop_bne, id_pkg::sel_jump, 2'b11};
			id_pkg::op_bgtz: {op, sel, r1} = {id_pkg::aluop_bgtz, id_pkg::sel_jump, 1'b1};
			id_pkg::op_blez: {op, sel, r1} = {id_pkg::aluop_blez, id_pkg::sel_jump, 1'b1};
			id_pkg::op_j: {op, sel} = {id_pkg::aluop_j, id_pkg::sel_jump};
			id_pkg::op_jal: {op, sel, wd, wr} = {id_pkg::aluop_jal, id_pkg::sel_jump, 5'd31, 1'b1};
			default: ;
		endcase
	endtask

	// load-use flag above the operand value
	function automatic logic [32:0] forward_operand(input logic rd, input logic [4:0] addr,
			input logic [31:0] imm);
		if (rd && ex_load_i && ex_wd_i == addr)
			return {1'b1, 32'h0};
		if (rd && ex_wreg_i && ex_wd_i == addr)
			return {1'b0, ex_wdata_i};
		if (rd && mem_wreg_i && mem_wd_i == addr)
			return {1'b0, mem_wdata_i};
		return rd ? {1'b0, rf[addr]} : {1'b0, imm};
	endfunction

	task automatic chk(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s expected %h actual %h at %0t", name, exp, act, $time);
		end
	endtask

	//////////////////////////////////////////////////
	// model step and checks on the falling edge
	always @(negedge clk) begin
		logic [7:0] d_op;
		logic [2:0] d_sel;
		logic [4:0] d_wd;
		logic d_wr, d_r1, d_r2, taken;
		logic [31:0] d_imm, pc4, target, link;
		logic [32:0] o1, o2;
		if (started) begin
			chk("ex_aluop_o", {24'h0, e_op}, {24'h0, ex_aluop_o});
			chk("ex_alusel_o", {29'h0, e_sel}, {29'h0, ex_alusel_o});
			chk("ex_wd_o", {27'h0, e_wd}, {27'h0, ex_wd_o});
			chk("ex_wreg_o", {31'h0, e_wr}, {31'h0, ex_wreg_o});
			chk("ex_reg1_o", e_r1, ex_reg1_o);
			chk("ex_reg2_o", e_r2, ex_reg2_o);
			chk("ex_link_addr_o", e_link, ex_link_addr_o);
			chk("ex_in_delayslot_o", {31'h0, e_ds}, {31'h0, ex_in_delayslot_o});
			chk("inst_invalid_o", {31'h0, e_inv}, {31'h0, inst_invalid_o});
		end
		decode_word(m_inst, d_op, d_sel, d_wd, d_wr, d_r1, d_r2, d_imm);
		o1 = forward_operand(d_r1, m_inst[25:21], d_imm);
		o2 = forward_operand(d_r2, m_inst[20:16], d_imm);
		m_stall = o1[32] | o2[32];
		chk("stall_o", {31'h0, m_stall}, {31'h0, stall_o});
		chk("reg1_read_o", {31'h0, d_r1}, {31'h0, reg1_read_o});
		chk("reg2_read_o", {31'h0, d_r2}, {31'h0, reg2_read_o});
		chk("reg1_addr_o", {27'h0, m_inst[25:21]}, {27'h0, reg1_addr_o});
		chk("reg2_addr_o", {27'h0, m_inst[20:16]}, {27'h0, reg2_addr_o});

		// branch rule
		pc4 = m_pc + 32'd4;
		target = pc4 + {{14{m_inst[15]}}, m_inst[15:0], 2'b00};
		link = 32'h0;
		case (d_op)
			id_pkg::aluop_beq:  taken = (o1[31:0] == o2[31:0]);
			id_pkg::aluop_bne:  taken = (o1[31:0] != o2[31:0]);
			id_pkg::aluop_bgtz: taken = !o1[31] && (o1[31:0] != 32'h0);
			id_pkg::aluop_blez: taken = o1[31] || (o1[31:0] == 32'h0);
			id_pkg::aluop_bgez: taken = !o1[31];
			id_pkg::aluop_bltz: taken = o1[31];
			id_pkg::aluop_j, id_pkg::aluop_jal: begin
				taken = 1'b1;
				target = {pc4[31:28], m_inst[25:0], 2'b00};
			end
			id_pkg::aluop_jr, id_pkg::aluop_jalr: begin
				taken = 1'b1;
				target = o1[31:0];
			end
			default: taken = 1'b0;
		endcase
		if (d_op == id_pkg::aluop_jal || d_op == id_pkg::aluop_jalr)
			link = m_pc + 32'd8;
		if (!taken)
			target = 32'h0;
		if (!m_stall) begin	// operands are don't-care under a load-use stall
			chk("branch_flag_o", {31'h0, taken}, {31'h0, branch_flag_o});
			chk("branch_target_o", target, branch_target_o);
			chk("next_in_delayslot_o", {31'h0, taken}, {31'h0, next_in_delayslot_o});
		end

		if (m_stall)
			{n_op, n_sel, n_wd, n_wr, n_r1, n_r2, n_link, n_ds, n_inv} = '0;	// bubble
		else
			{n_op, n_sel, n_wd, n_wr, n_r1, n_r2, n_link, n_ds, n_inv} = {d_op, d_sel, d_wd,
				d_wr, o1[31:0], o2[31:0], link, m_ds, d_sel == id_pkg::sel_nop};
	end

	// registers of the model follow the rising edge
	always @(posedge clk) begin
		started <= 1'b1;
		cycles <= cycles + 1;
		if (reset_i) begin
			{m_pc, m_inst, m_ds} <= '0;
			{e_op, e_sel, e_wd, e_wr, e_r1, e_r2, e_link, e_ds, e_inv} <= '0;
		end else begin
			{e_op, e_sel, e_wd, e_wr, e_r1, e_r2, e_link, e_ds, e_inv} <= {n_op, n_sel, n_wd,
				n_wr, n_r1, n_r2, n_link, n_ds, n_inv};
			if (!m_stall)
				{m_pc, m_inst, m_ds} <= if_valid_i ? {pc_i, inst_i, in_delayslot_i} : '0;
		end
		if (cycles > cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus
	initial begin
		logic [31:0] r;
		int issued;
		issued = 0;
		for (int k = 0; k < 32; k++)
			rf[k] = next_rand();
		{reset_i, if_valid_i, in_delayslot_i} = 3'b100;
		{pc_i, inst_i, ex_wdata_i, mem_wdata_i} = '0;
		{ex_wreg_i, ex_load_i, mem_wreg_i, ex_wd_i, mem_wd_i} = '0;
		repeat (8) @(posedge clk);
		reset_i <= 1'b0;
		while (issued < num_instr) begin
			@(posedge clk);
			r = next_rand();
			if (!m_stall) begin	// fetch holds its word during a stall
				if_valid_i <= (r[2:0] != 3'd0);
				pc_i <= (r[7:3] == 5'd0) ? (next_rand() & 32'hffff_fffc) : pc_i + 32'd4;
				inst_i <= gen_inst();
				in_delayslot_i <= r[8];
				issued++;
			end
			ex_wreg_i <= r[9];
			ex_load_i <= (r[12:10] == 3'd0);
			ex_wd_i <= {2'b0, r[15:13]};
			mem_wreg_i <= r[16];
			mem_wd_i <= {2'b0, r[19:17]};
			ex_wdata_i <= next_rand();
			mem_wdata_i <= next_rand();
		end
		ex_load_i <= 1'b0;	// no further load-use, the last words retire in fixed time
		repeat (3) @(posedge clk);
		$display("checks %0d, mismatches %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
